// ==== src/l1i_pkg.sv ====
// ---------------------------------------------------------------------------
// L1 instruction cache shared definitions
// Cache geometry constants plus tag, chunk, block and way types
// ---------------------------------------------------------------------------

package l1i_pkg;

    // ---------------------------------------------------------------------------
    // geometry

    // physical tag bits kept per block
    localparam int TAG_WIDTH = 22;

    // one fetch chunk is what the core gets per lookup
    localparam int FETCH_BYTES = 16;
    localparam int BLOCK_BYTES = 32;
    localparam int CHUNKS_PER_BLOCK = BLOCK_BYTES / FETCH_BYTES;

    localparam int DEFAULT_NUM_SETS = 128;

    // ---------------------------------------------------------------------------
    // types

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // chunk position inside a block
    typedef logic [$clog2(CHUNKS_PER_BLOCK)-1:0] chunk_idx_t;

    typedef logic [FETCH_BYTES*8-1:0] fetch_t;

    // whole block from L2, chunk 0 in the low bits
    typedef logic [BLOCK_BYTES*8-1:0] block_t;

    typedef logic way_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

// ==== src/l1i_way_ram.sv ====
// ---------------------------------------------------------------------------
// Two-way synchronous array with one read and one write port
// Each row holds one entry per way. Reads take one cycle and see a write
// to the same row in the same cycle.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i_way_ram #(
    parameter type entry_t = logic [7:0],
    parameter int DEPTH = 128,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input logic CLK,
    input logic nRST,

    input logic rd_en,
    input logic [ADDR_WIDTH-1:0] rd_addr,
    output entry_t rd_data [2],

    input logic [1:0] wr_way_mask,
    input logic [ADDR_WIDTH-1:0] wr_addr,
    input entry_t wr_data
);

    entry_t mem [2][DEPTH];

    // rows never written since reset read back as zero
    logic [1:0][DEPTH-1:0] written;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            written <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_way_mask[w]) begin
                    written[w][wr_addr] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_way_mask[w]) begin
                mem[w][wr_addr] <= wr_data;
            end
            if (rd_en) begin
                // write-first on a row collision
                if (wr_way_mask[w] && (wr_addr == rd_addr)) begin
                    rd_data[w] <= wr_data;
                end else if (written[w][rd_addr]) begin
                    rd_data[w] <= mem[w][rd_addr];
                end else begin
                    rd_data[w] <= '0;
                end
            end
        end
    end

    a_mask_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(wr_way_mask))
        else $error("way_ram: write mask unknown");

endmodule

// ==== src/l1i_tag_store.sv ====
// ---------------------------------------------------------------------------
// L1I tag store
// Tag array for both ways plus one LRU bit per set. Fills write tags one
// chunk at a time and hits refresh the LRU bit of the set just read.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i_tag_store #(
    parameter int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input logic CLK,
    input logic nRST,

    // lookup read
    input logic rd_valid,
    input logic [INDEX_WIDTH-1:0] rd_index,
    output l1i_pkg::tag_entry_t tag_entries [2],
    output l1i_pkg::way_t victim_way,

    // hit feedback
    input logic hit_valid,
    input l1i_pkg::way_t hit_way,

    // fill from miss unit
    input logic fill_valid,
    input l1i_pkg::way_t fill_way,
    input logic [INDEX_WIDTH-1:0] fill_index,
    input l1i_pkg::tag_t fill_tag,
    input logic fill_last
);

    // bit set means way 1 is the next victim
    logic [NUM_SETS-1:0] lru;
    logic [INDEX_WIDTH-1:0] rd_index_q;

    logic [1:0] wr_mask;
    l1i_pkg::tag_entry_t wr_entry;

    // tag turns valid only with the last chunk of the block
    assign wr_mask = fill_valid ? (2'b01 << fill_way) : 2'b00;
    assign wr_entry = {fill_last, fill_tag};

    l1i_way_ram #(
        .entry_t(l1i_pkg::tag_entry_t),
        .DEPTH(NUM_SETS)
    ) tag_ram (
        .CLK(CLK),
        .nRST(nRST),
        .rd_en(rd_valid),
        .rd_addr(rd_index),
        .rd_data(tag_entries),
        .wr_way_mask(wr_mask),
        .wr_addr(fill_index),
        .wr_data(wr_entry)
    );

    always_ff @(posedge CLK) begin
        if (rd_valid) begin
            rd_index_q <= rd_index;
        end
    end

    assign victim_way = lru[rd_index_q];

    // ---------------------------------------------------------------------------
    // LRU update, the used way becomes most recent

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else begin
            if (hit_valid) begin
                lru[rd_index_q] <= ~hit_way;
            end
            if (fill_valid && fill_last) begin
                lru[fill_index] <= ~fill_way;
            end
        end
    end

endmodule

// ==== src/l1i_data_store.sv ====
// ---------------------------------------------------------------------------
// L1I data store
// Holds fetch chunks of both ways, one row per set and chunk number
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i_data_store #(
    parameter int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input logic CLK,
    input logic nRST,

    input logic rd_valid,
    input logic [INDEX_WIDTH-1:0] rd_index,
    input l1i_pkg::chunk_idx_t rd_chunk,
    output l1i_pkg::fetch_t chunks [2],

    input logic fill_valid,
    input l1i_pkg::way_t fill_way,
    input logic [INDEX_WIDTH-1:0] fill_index,
    input l1i_pkg::chunk_idx_t fill_chunk,
    input l1i_pkg::fetch_t fill_data
);

    logic [1:0] wr_mask;

    assign wr_mask = fill_valid ? (2'b01 << fill_way) : 2'b00;

    // row = {set index, chunk number}
    l1i_way_ram #(
        .entry_t(l1i_pkg::fetch_t),
        .DEPTH(NUM_SETS * l1i_pkg::CHUNKS_PER_BLOCK)
    ) data_ram (
        .CLK(CLK),
        .nRST(nRST),
        .rd_en(rd_valid),
        .rd_addr({rd_index, rd_chunk}),
        .rd_data(chunks),
        .wr_way_mask(wr_mask),
        .wr_addr({fill_index, fill_chunk}),
        .wr_data(fill_data)
    );

endmodule

// ==== src/l1i_hit_select.sv ====
// ---------------------------------------------------------------------------
// L1I hit selector
// Compares the lookup tag with both ways and returns the hitting chunk.
// A miss offers its address and the victim way to the miss unit.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i_hit_select #(
    parameter int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input logic CLK,
    input logic nRST,

    input logic req_valid,
    input l1i_pkg::tag_t req_tag,
    input logic [INDEX_WIDTH-1:0] req_index,

    // array results, one cycle after the request
    input l1i_pkg::tag_entry_t tag_entries [2],
    input l1i_pkg::fetch_t chunks [2],
    input l1i_pkg::way_t victim_way,

    output logic resp_valid,
    output logic resp_hit,
    output l1i_pkg::fetch_t resp_instr,

    output logic hit_valid,
    output l1i_pkg::way_t hit_way,

    output logic miss_valid,
    output l1i_pkg::tag_t miss_tag,
    output logic [INDEX_WIDTH-1:0] miss_index,
    output l1i_pkg::way_t miss_way
);

    logic req_valid_q;
    l1i_pkg::tag_t req_tag_q;
    logic [INDEX_WIDTH-1:0] req_index_q;
    logic [1:0] match;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        req_tag_q <= req_tag;
        req_index_q <= req_index;
    end

    assign match[0] = tag_entries[0].valid && (tag_entries[0].tag == req_tag_q);
    assign match[1] = tag_entries[1].valid && (tag_entries[1].tag == req_tag_q);

    // way 0 wins if both ways match
    assign hit_way = l1i_pkg::way_t'(!match[0]);
    assign resp_valid = req_valid_q;
    assign resp_hit = req_valid_q && (match != 2'b00);
    assign resp_instr = chunks[hit_way];
    assign hit_valid = resp_hit;

    assign miss_valid = req_valid_q && (match == 2'b00);
    assign miss_tag = req_tag_q;
    assign miss_index = req_index_q;
    assign miss_way = victim_way;

endmodule

// ==== src/l1i_miss_unit.sv ====
// ---------------------------------------------------------------------------
// L1I miss unit
// Takes one miss at a time, requests its block from L2, captures the
// matching response and writes the block into the victim way chunk by chunk
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i_miss_unit #(
    parameter int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int ADDR_WIDTH = l1i_pkg::TAG_WIDTH + INDEX_WIDTH
) (
    input logic CLK,
    input logic nRST,

    input logic miss_valid,
    input l1i_pkg::tag_t miss_tag,
    input logic [INDEX_WIDTH-1:0] miss_index,
    input l1i_pkg::way_t miss_way,

    output logic l2_req_valid,
    output logic [ADDR_WIDTH-1:0] l2_req_addr,
    input logic l2_req_ready,

    input logic l2_resp_valid,
    input logic [ADDR_WIDTH-1:0] l2_resp_addr,
    input l1i_pkg::block_t l2_resp_block,

    output logic fill_valid,
    output l1i_pkg::way_t fill_way,
    output logic [INDEX_WIDTH-1:0] fill_index,
    output l1i_pkg::chunk_idx_t fill_chunk,
    output l1i_pkg::tag_t fill_tag,
    output l1i_pkg::fetch_t fill_data,
    output logic fill_last
);

    localparam int CHUNK_BITS = $bits(l1i_pkg::fetch_t);
    localparam l1i_pkg::chunk_idx_t LAST_CHUNK =
        l1i_pkg::chunk_idx_t'(l1i_pkg::CHUNKS_PER_BLOCK - 1);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_FILL} state_t;

    state_t state;
    state_t state_next;
    l1i_pkg::chunk_idx_t chunk_cnt;

    // open miss
    l1i_pkg::tag_t tag_q;
    logic [INDEX_WIDTH-1:0] index_q;
    l1i_pkg::way_t way_q;
    l1i_pkg::block_t block_q;

    logic miss_take;
    logic block_take;

    // misses seen while busy are dropped, the core retries them
    assign miss_take = (state == S_IDLE) && miss_valid;
    assign block_take = (state == S_WAIT) && l2_resp_valid && (l2_resp_addr == l2_req_addr);

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (miss_take) state_next = S_REQ;
            end
            S_REQ: begin
                if (l2_req_ready) state_next = S_WAIT;
            end
            S_WAIT: begin
                if (block_take) state_next = S_FILL;
            end
            default: begin
                if (fill_last) state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= S_IDLE;
            chunk_cnt <= '0;
        end else begin
            state <= state_next;
            if (block_take) begin
                chunk_cnt <= '0;
            end else if (state == S_FILL) begin
                chunk_cnt <= chunk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_take) begin
            tag_q <= miss_tag;
            index_q <= miss_index;
            way_q <= miss_way;
        end
        if (block_take) begin
            block_q <= l2_resp_block;
        end
    end

    // ---------------------------------------------------------------------------
    // L2 request and fill outputs

    assign l2_req_valid = (state == S_REQ);
    assign l2_req_addr = {tag_q, index_q};

    assign fill_valid = (state == S_FILL);
    assign fill_way = way_q;
    assign fill_index = index_q;
    assign fill_chunk = chunk_cnt;
    assign fill_tag = tag_q;
    assign fill_data = block_q[chunk_cnt*CHUNK_BITS +: CHUNK_BITS];
    assign fill_last = fill_valid && (chunk_cnt == LAST_CHUNK);

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_addr))
        else $error("miss_unit: L2 request changed before ready");

    // a response for the open miss must find the unit waiting for it
    a_resp_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
        l2_resp_valid && (l2_resp_addr == l2_req_addr) && (state != S_IDLE)
            |-> state == S_WAIT)
        else $error("miss_unit: response for the open miss outside the wait state");

endmodule

// ==== src/l1i.sv ====
// ---------------------------------------------------------------------------
// L1 instruction cache top level
// Blocking two-way set-associative cache. Tag and data stores are read
// side by side, the hit selector answers the core and the miss unit
// refills the victim way from L2.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module l1i #(
    parameter int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int ADDR_WIDTH = l1i_pkg::TAG_WIDTH + INDEX_WIDTH
) (
    input logic CLK,
    input logic nRST,

    // core lookup
    input logic core_req_valid,
    input l1i_pkg::tag_t core_req_tag,
    input logic [INDEX_WIDTH-1:0] core_req_index,
    input l1i_pkg::chunk_idx_t core_req_chunk,
    output logic core_resp_valid,
    output logic core_resp_hit,
    output l1i_pkg::fetch_t core_resp_instr,

    // L2 request and response
    output logic l2_req_valid,
    output logic [ADDR_WIDTH-1:0] l2_req_addr,
    input logic l2_req_ready,
    input logic l2_resp_valid,
    input logic [ADDR_WIDTH-1:0] l2_resp_addr,
    input l1i_pkg::block_t l2_resp_block
);

    l1i_pkg::tag_entry_t tag_entries [2];
    l1i_pkg::fetch_t chunks [2];
    l1i_pkg::way_t victim_way;

    logic hit_valid;
    l1i_pkg::way_t hit_way;

    logic miss_valid;
    l1i_pkg::tag_t miss_tag;
    logic [INDEX_WIDTH-1:0] miss_index;
    l1i_pkg::way_t miss_way;

    logic fill_valid;
    l1i_pkg::way_t fill_way;
    logic [INDEX_WIDTH-1:0] fill_index;
    l1i_pkg::chunk_idx_t fill_chunk;
    l1i_pkg::tag_t fill_tag;
    l1i_pkg::fetch_t fill_data;
    logic fill_last;

    l1i_tag_store #(.NUM_SETS(NUM_SETS)) tag_store (
        .CLK(CLK), .nRST(nRST),
        .rd_valid(core_req_valid), .rd_index(core_req_index),
        .tag_entries(tag_entries), .victim_way(victim_way),
        .hit_valid(hit_valid), .hit_way(hit_way),
        .fill_valid(fill_valid), .fill_way(fill_way), .fill_index(fill_index),
        .fill_tag(fill_tag), .fill_last(fill_last)
    );

    l1i_data_store #(.NUM_SETS(NUM_SETS)) data_store (
        .CLK(CLK), .nRST(nRST),
        .rd_valid(core_req_valid), .rd_index(core_req_index), .rd_chunk(core_req_chunk),
        .chunks(chunks),
        .fill_valid(fill_valid), .fill_way(fill_way), .fill_index(fill_index),
        .fill_chunk(fill_chunk), .fill_data(fill_data)
    );

    l1i_hit_select #(.NUM_SETS(NUM_SETS)) hit_select (
        .CLK(CLK), .nRST(nRST),
        .req_valid(core_req_valid), .req_tag(core_req_tag), .req_index(core_req_index),
        .tag_entries(tag_entries), .chunks(chunks), .victim_way(victim_way),
        .resp_valid(core_resp_valid), .resp_hit(core_resp_hit),
        .resp_instr(core_resp_instr),
        .hit_valid(hit_valid), .hit_way(hit_way),
        .miss_valid(miss_valid), .miss_tag(miss_tag), .miss_index(miss_index),
        .miss_way(miss_way)
    );

    l1i_miss_unit #(.NUM_SETS(NUM_SETS)) miss_unit (
        .CLK(CLK), .nRST(nRST),
        .miss_valid(miss_valid), .miss_tag(miss_tag), .miss_index(miss_index),
        .miss_way(miss_way),
        .l2_req_valid(l2_req_valid), .l2_req_addr(l2_req_addr), .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid), .l2_resp_addr(l2_resp_addr),
        .l2_resp_block(l2_resp_block),
        .fill_valid(fill_valid), .fill_way(fill_way), .fill_index(fill_index),
        .fill_chunk(fill_chunk), .fill_tag(fill_tag), .fill_data(fill_data),
        .fill_last(fill_last)
    );

endmodule

// ==== sim/tb_clock.sv ====
// ---------------------------------------------------------------------------
// Testbench clock and reset
// Free running clock and an active low reset held for a few cycles
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 100ns,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // release away from the rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// ==== sim/tb_l1i.sv ====
// ---------------------------------------------------------------------------
// L1I testbench
// Random and directed lookups against an L2 and memory model, with a
// reference model of tags and LRU bits per set
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_l1i;

    localparam int NUM_SETS = l1i_pkg::DEFAULT_NUM_SETS;
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int ADDR_WIDTH = l1i_pkg::TAG_WIDTH + INDEX_WIDTH;
    localparam int CHUNK_BITS = $bits(l1i_pkg::fetch_t);
    localparam logic [31:0] SEED = 32'h1e07;
    localparam int MAX_DELAY = 8;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_ACCESSES = NUM_RANDOM + 6;
    localparam int CYCLE_LIMIT = 40 * NUM_ACCESSES;

    typedef logic [ADDR_WIDTH-1:0] l2_addr_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    logic CLK;
    logic nRST;
    logic core_req_valid;
    l1i_pkg::tag_t core_req_tag;
    index_t core_req_index;
    l1i_pkg::chunk_idx_t core_req_chunk;
    logic core_resp_valid;
    logic core_resp_hit;
    l1i_pkg::fetch_t core_resp_instr;
    logic l2_req_valid;
    l2_addr_t l2_req_addr;
    logic l2_req_ready;
    logic l2_resp_valid;
    l2_addr_t l2_resp_addr;
    l1i_pkg::block_t l2_resp_block;

    // reference model
    logic m_valid [NUM_SETS][2];
    l1i_pkg::tag_t m_tag [NUM_SETS][2];
    logic m_lru [NUM_SETS];

    l2_addr_t exp_addr;
    int stall_cycles;
    int l2_delay;
    int cycle_count;

    tb_clock clock_gen (.CLK(CLK), .nRST(nRST));

    l1i #(.NUM_SETS(NUM_SETS)) l1i_inst (.*);

    // ---------------------------------------------------------------------------
    // failure reporting and compare tasks

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_instr(input l1i_pkg::fetch_t got, input l1i_pkg::fetch_t exp,
                               input string what);
        if (got !== exp) begin
            stop_with_fail($sformatf("ERROR at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_fail($sformatf("ERROR at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input l2_addr_t got, input l2_addr_t exp, input string what);
        if (got !== exp) begin
            stop_with_fail($sformatf("ERROR at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    // memory contents hashed from the whole address, chunk and seed
    function automatic l1i_pkg::fetch_t mem_chunk(input l2_addr_t addr,
                                                  input l1i_pkg::chunk_idx_t c);
        l1i_pkg::fetch_t v;
        logic [31:0] h;
        for (int i = 0; i < CHUNK_BITS / 32; i++) begin
            h = (32'(addr) * 32'h9e37_79b1) ^ SEED ^ ((32'(c) * 4 + i) * 32'h85eb_ca6b);
            h = h ^ (h >> 13);
            v[i*32 +: 32] = h;
        end
        return v;
    endfunction

    function automatic l1i_pkg::block_t mem_block(input l2_addr_t addr);
        l1i_pkg::block_t b;
        for (int c = 0; c < l1i_pkg::CHUNKS_PER_BLOCK; c++) begin
            b[c*CHUNK_BITS +: CHUNK_BITS] = mem_chunk(addr, l1i_pkg::chunk_idx_t'(c));
        end
        return b;
    endfunction

    // tag top bit is never used by the lookups
    task automatic send_stray_response();
        l2_resp_valid <= 1'b1;
        l2_resp_addr <= {1'b1, (ADDR_WIDTH-1)'($urandom)};
        l2_resp_block <= {8{$urandom}};
    endtask

    // ---------------------------------------------------------------------------
    // L2 model, random ready and delayed answers plus stray responses

    initial begin
        bit outstanding;
        bit hold_check;
        l2_addr_t hold_addr;
        l2_addr_t pend_addr;
        int delay;
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_addr = '0;
        l2_resp_block = '0;
        outstanding = 0;
        hold_check = 0;
        hold_addr = '0;
        pend_addr = '0;
        delay = 0;
        forever begin
            @(posedge CLK);
            if (nRST) begin
                l2_req_ready <= ($urandom_range(0, 1) == 1);
                l2_resp_valid <= 1'b0;
                if (hold_check) begin
                    check_flag(l2_req_valid, 1'b1, "L2 request held");
                    check_addr(l2_req_addr, hold_addr, "L2 request address held");
                end
                hold_check = l2_req_valid && !l2_req_ready;
                hold_addr = l2_req_addr;
                if (l2_req_valid && !l2_req_ready) stall_cycles++;
                if (l2_req_valid && l2_req_ready) begin
                    if (outstanding) begin
                        stop_with_fail("second L2 request before the first was answered");
                    end
                    check_addr(l2_req_addr, exp_addr, "L2 request address");
                    outstanding = 1;
                    pend_addr = l2_req_addr;
                    delay = $urandom_range(2, MAX_DELAY);
                    l2_delay = delay;
                end else if (outstanding) begin
                    delay--;
                    if (delay == 0) begin
                        l2_resp_valid <= 1'b1;
                        l2_resp_addr <= pend_addr;
                        l2_resp_block <= mem_block(pend_addr);
                        outstanding = 0;
                    end else if ($urandom_range(0, 2) == 0) begin
                        // stale response while the miss waits
                        send_stray_response();
                    end
                end else if ($urandom_range(0, 5) == 0) begin
                    send_stray_response();
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_with_fail("timeout, the cycle limit was reached before the tests ended");
        end
    end

    // ---------------------------------------------------------------------------
    // lookup with retries until hit, checked against the model

    task automatic run_access(input l1i_pkg::tag_t tag, input index_t idx,
                              input l1i_pkg::chunk_idx_t chunk, output logic first_hit);
        logic exp_hit;
        int way;
        int n;
        int stall_start;
        bit done;
        exp_hit = 1'b0;
        way = m_lru[idx];
        for (int w = 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                way = w;
            end
        end
        exp_addr = {tag, idx};
        stall_start = stall_cycles;
        @(posedge CLK);
        core_req_valid <= 1'b1;
        core_req_tag <= tag;
        core_req_index <= idx;
        core_req_chunk <= chunk;
        @(negedge CLK);
        check_flag(core_resp_valid, 1'b0, "response valid without request");
        n = 0;
        done = 0;
        first_hit = 1'b0;
        while (!done) begin
            @(posedge CLK);
            @(negedge CLK);
            check_flag(core_resp_valid, 1'b1, "response valid");
            if (n == 0) begin
                first_hit = core_resp_hit;
                check_flag(core_resp_hit, exp_hit, "first lookup hit");
            end
            if (core_resp_hit) begin
                check_instr(core_resp_instr, mem_chunk({tag, idx}, chunk), "hit chunk");
                done = 1;
            end else if (n > l2_delay + l1i_pkg::CHUNKS_PER_BLOCK + 3
                             + (stall_cycles - stall_start)) begin
                stop_with_fail("retried miss did not turn into a hit in time");
            end
            n++;
        end
        // one more request was already in flight
        @(posedge CLK);
        core_req_valid <= 1'b0;
        @(negedge CLK);
        check_flag(core_resp_valid, 1'b1, "trailing response valid");
        check_flag(core_resp_hit, 1'b1, "trailing response hit");
        check_instr(core_resp_instr, mem_chunk({tag, idx}, chunk), "trailing chunk");
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way] = tag;
        m_lru[idx] = (way == 0);
    endtask

    initial begin
        logic hit;
        void'($urandom(SEED));
        core_req_valid = 1'b0;
        core_req_tag = '0;
        core_req_index = '0;
        core_req_chunk = '0;
        exp_addr = '0;
        stall_cycles = 0;
        l2_delay = 0;
        cycle_count = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s] = 1'b0;
        end
        @(posedge nRST);
        @(negedge CLK);
        check_flag(core_resp_valid, 1'b0, "response valid after reset");
        check_flag(l2_req_valid, 1'b0, "L2 request valid after reset");

        // replacement, B is the victim after A was used
        run_access(22'h0a1, 5, 0, hit);
        check_flag(hit, 1'b0, "directed A first lookup");
        run_access(22'h0b2, 5, 1, hit);
        check_flag(hit, 1'b0, "directed B first lookup");
        run_access(22'h0a1, 5, 1, hit);
        check_flag(hit, 1'b1, "directed A hit");
        run_access(22'h0c3, 5, 0, hit);
        check_flag(hit, 1'b0, "directed C first lookup");
        run_access(22'h0a1, 5, 0, hit);
        check_flag(hit, 1'b1, "directed A kept");
        run_access(22'h0b2, 5, 0, hit);
        check_flag(hit, 1'b0, "directed B evicted");

        // small pool so sets see hits and evictions
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_access(l1i_pkg::tag_t'(22'h100 + $urandom_range(0, 5)),
                       index_t'(4 * $urandom_range(0, 3) + 1),
                       l1i_pkg::chunk_idx_t'($urandom_range(0, 1)), hit);
        end

        repeat (2) @(posedge CLK);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== l1i.f ====
src/l1i_pkg.sv
src/l1i_way_ram.sv
src/l1i_tag_store.sv
src/l1i_data_store.sv
src/l1i_hit_select.sv
src/l1i_miss_unit.sv
src/l1i.sv
sim/tb_clock.sv
sim/tb_l1i.sv

// ==== Makefile ====
# Verilator build and run for the L1 instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1i
FLIST     ?= l1i.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
